//--- cache_cfg_pkg.sv
package cache_cfg_pkg;

   // address and data widths
   parameter int ADDR_W = 32;
   parameter int WORD_W = 32;

   // address split
   parameter int IDX_W  = 3;
   parameter int BLK_W  = 1;
   parameter int BYTE_W = 2;
   parameter int TAG_W  = ADDR_W - IDX_W - BLK_W - BYTE_W;

   // sets per way
   parameter int NUM_SETS = 8;

   // where the hit counter lands after a flush
   parameter logic [ADDR_W-1:0] HIT_COUNT_ADDR = 32'h0000_3100;

   // lookup view of an address
   typedef struct packed {
      logic [TAG_W-1:0]  tag;
      logic [IDX_W-1:0]  idx;
      logic [BLK_W-1:0]  blkoff;
      logic [BYTE_W-1:0] byteoff;
   } addr_fields_t;

   // raw word for the bus, fields for the tag compare
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      addr_fields_t      f;
   } addr_u;

   // one cache block, word 1 in the upper half
   typedef struct packed {
      logic                   valid;
      logic                   dirty;
      logic [TAG_W-1:0]       tag;
      logic [1:0][WORD_W-1:0] data;
   } frame_t;

   // word aligned address of one word in a block
   function automatic addr_u make_addr(input logic [TAG_W-1:0] tag,
                                       input logic [IDX_W-1:0] idx,
                                       input logic [BLK_W-1:0] off);
      addr_u a;
      a.f.tag     = tag;
      a.f.idx     = idx;
      a.f.blkoff  = off;
      a.f.byteoff = '0;
      return a;
   endfunction

endpackage

//--- mem_bus_pkg.sv
package mem_bus_pkg;

   // processor request, rd or wr marks it valid
   // held by the processor until hit comes back
   typedef struct packed {
      logic                                rd;
      logic                                wr;
      cache_cfg_pkg::addr_u                addr;
      logic [cache_cfg_pkg::WORD_W-1:0]    wdata;
   } cpu_req_t;

   // hit doubles as ready
   // rdata only meaningful while hit is high on a read
   typedef struct packed {
      logic                                hit;
      logic [cache_cfg_pkg::WORD_W-1:0]    rdata;
   } cpu_resp_t;

   // memory request, held stable until ready
   // valid without wr means a read
   typedef struct packed {
      logic                                valid;
      logic                                wr;
      cache_cfg_pkg::addr_u                addr;
      logic [cache_cfg_pkg::WORD_W-1:0]    wdata;
   } mem_req_t;

   // transfer happens when valid and ready are both high
   typedef struct packed {
      logic                                ready;
      logic [cache_cfg_pkg::WORD_W-1:0]    rdata;
   } mem_resp_t;

endpackage

//--- dcache_ways.sv
`timescale 1ns/1ps

module dcache_ways
#(
   parameter int NUM_SETS = cache_cfg_pkg::NUM_SETS
)
(
   input  logic                             CLK,
   input  logic                             nRST,
   input  cache_cfg_pkg::addr_u             lookup_addr,
   input  logic                             fill_en,
   input  logic                             fill_way,
   input  cache_cfg_pkg::frame_t            fill_frame,
   input  logic                             touch_en,
   input  logic                             flush_way,
   input  logic [cache_cfg_pkg::IDX_W-1:0]  flush_idx,
   output logic                             hit,
   output logic                             hit_way,
   output logic                             victim_way,
   output cache_cfg_pkg::frame_t            victim_frame,
   output cache_cfg_pkg::frame_t            hit_frame,
   output cache_cfg_pkg::frame_t            flush_frame
);
   import cache_cfg_pkg::*;

   // both ways, first index picks the way
   frame_t frames [2][NUM_SETS];

   // per set, points at the way to replace next
   logic [NUM_SETS-1:0] lru;

   logic [IDX_W-1:0] idx;
   frame_t           way0_frame;
   frame_t           way1_frame;
   logic             hit0;
   logic             hit1;
   logic             used_way;

   // set selected by the processor address
   assign idx = lookup_addr.f.idx;

   assign way0_frame = frames[0][idx];
   assign way1_frame = frames[1][idx];

   // tag compare in both ways
   assign hit0 = way0_frame.valid && (way0_frame.tag == lookup_addr.f.tag);
   assign hit1 = way1_frame.valid && (way1_frame.tag == lookup_addr.f.tag);

   // a tag lives in at most one way of a set
   assign hit      = hit0 | hit1;
   assign hit_way  = hit1;
   assign hit_frame = hit_way ? way1_frame : way0_frame;

   // lru way of the set is evicted
   // after reset way 0 goes first, then way 1
   assign victim_way   = lru[idx];
   assign victim_frame = frames[victim_way][idx];

   // second read port for the flush walker
   assign flush_frame = frames[flush_way][flush_idx];

   // way that was just used
   // fill covers write hits and miss fills, else a read hit
   assign used_way = fill_en ? fill_way : hit_way;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         for (int s = 0; s < NUM_SETS; s++)
         begin
            frames[0][s] <= '0;
            frames[1][s] <= '0;
         end
         lru <= '0;
      end
      else
      begin
         // whole block write
         if (fill_en)
         begin
            frames[fill_way][idx] <= fill_frame;
         end
         // lru points away from the way just touched
         if (touch_en)
         begin
            lru[idx] <= ~used_way;
         end
      end
   end

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
(
   input  logic                              CLK,
   input  logic                              nRST,
   input  mem_bus_pkg::cpu_req_t             cpu_req,
   input  logic                              halt,
   input  logic                              hit,
   input  logic                              hit_way,
   input  logic                              victim_way,
   input  cache_cfg_pkg::frame_t             victim_frame,
   input  cache_cfg_pkg::frame_t             hit_frame,
   input  mem_bus_pkg::mem_resp_t            ctrl_mem_resp,
   output mem_bus_pkg::cpu_resp_t            cpu_resp,
   output mem_bus_pkg::mem_req_t             ctrl_mem_req,
   output cache_cfg_pkg::addr_u              lookup_addr,
   output logic                              fill_en,
   output logic                              fill_way,
   output cache_cfg_pkg::frame_t             fill_frame,
   output logic                              touch_en,
   output logic                              flush_start,
   output logic [cache_cfg_pkg::WORD_W-1:0]  hit_count
);
   import cache_cfg_pkg::*;

   typedef enum logic [2:0] {
      idle,
      wb_first,
      wb_second,
      fetch_first,
      fetch_second,
      halted
   } state_t;

   state_t            state;
   state_t            state_nxt;
   logic [WORD_W-1:0] first_word;
   logic              req_valid;
   logic [BLK_W-1:0]  req_off;
   logic [BLK_W-1:0]  wb_off;
   logic              count_hit;

   // arrays always look up the live request
   assign lookup_addr = cpu_req.addr;
   assign req_valid   = cpu_req.rd | cpu_req.wr;
   assign req_off     = cpu_req.addr.f.blkoff;

   // victim written back word 0 first
   assign wb_off = (state == wb_second) ? 1'b1 : 1'b0;

   // one pulse, the FSM leaves idle right after
   assign flush_start = (state == idle) && halt;

   // only hits answered from idle count, once per request
   assign count_hit = (state == idle) && !halt && req_valid && hit;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state     <= idle;
         hit_count <= '0;
      end
      else
      begin
         state <= state_nxt;
         if (count_hit)
         begin
            hit_count <= hit_count + 1'b1;
         end
      end
   end

   // requested word, kept until the block is complete
   always_ff @(posedge CLK)
   begin
      if ((state == fetch_first) && ctrl_mem_resp.ready)
      begin
         first_word <= ctrl_mem_resp.rdata;
      end
   end

   always_comb
   begin
      state_nxt    = state;
      cpu_resp     = '0;
      ctrl_mem_req = '0;
      fill_en      = 1'b0;
      fill_way     = hit_way;
      fill_frame   = hit_frame;
      touch_en     = 1'b0;
      case (state)
         idle:
         begin
            if (halt)
            begin
               state_nxt = halted;
            end
            else if (req_valid && hit)
            begin
               // answered in the request cycle
               cpu_resp.hit   = 1'b1;
               cpu_resp.rdata = hit_frame.data[req_off];
               touch_en       = 1'b1;
               if (cpu_req.wr)
               begin
                  // store word merged, block now dirty
                  fill_en                   = 1'b1;
                  fill_frame.dirty          = 1'b1;
                  fill_frame.data[req_off]  = cpu_req.wdata;
               end
            end
            else if (req_valid)
            begin
               // dirty victim goes out before the fetch
               if (victim_frame.valid && victim_frame.dirty)
               begin
                  state_nxt = wb_first;
               end
               else
               begin
                  state_nxt = fetch_first;
               end
            end
         end
         wb_first, wb_second:
         begin
            // victim's own tag gives the address
            ctrl_mem_req.valid = 1'b1;
            ctrl_mem_req.wr    = 1'b1;
            ctrl_mem_req.addr  = make_addr(victim_frame.tag, lookup_addr.f.idx, wb_off);
            ctrl_mem_req.wdata = victim_frame.data[wb_off];
            if (ctrl_mem_resp.ready)
            begin
               state_nxt = (state == wb_first) ? wb_second : fetch_first;
            end
         end
         fetch_first:
         begin
            // requested word first
            ctrl_mem_req.valid = 1'b1;
            ctrl_mem_req.addr  = make_addr(lookup_addr.f.tag, lookup_addr.f.idx, req_off);
            if (ctrl_mem_resp.ready)
            begin
               state_nxt = fetch_second;
            end
         end
         fetch_second:
         begin
            // the other word of the block
            ctrl_mem_req.valid = 1'b1;
            ctrl_mem_req.addr  = make_addr(lookup_addr.f.tag, lookup_addr.f.idx, ~req_off);
            if (ctrl_mem_resp.ready)
            begin
               cpu_resp.hit              = 1'b1;
               cpu_resp.rdata            = first_word;
               fill_en                   = 1'b1;
               fill_way                  = victim_way;
               fill_frame.valid          = 1'b1;
               fill_frame.dirty          = cpu_req.wr;
               fill_frame.tag            = lookup_addr.f.tag;
               fill_frame.data[req_off]  = cpu_req.wr ? cpu_req.wdata : first_word;
               fill_frame.data[~req_off] = ctrl_mem_resp.rdata;
               touch_en                  = 1'b1;
               state_nxt                 = idle;
            end
         end
         halted:
         begin
            // flush engine owns memory until reset
         end
         default:
         begin
            state_nxt = idle;
         end
      endcase
   end

endmodule

//--- dcache_flush.sv
`timescale 1ns/1ps

module dcache_flush
#(
   parameter int                                NUM_SETS       = cache_cfg_pkg::NUM_SETS,
   parameter logic [cache_cfg_pkg::ADDR_W-1:0]  HIT_COUNT_ADDR = cache_cfg_pkg::HIT_COUNT_ADDR
)
(
   input  logic                              CLK,
   input  logic                              nRST,
   input  logic                              flush_start,
   input  logic [cache_cfg_pkg::WORD_W-1:0]  hit_count,
   input  cache_cfg_pkg::frame_t             flush_frame,
   input  mem_bus_pkg::mem_req_t             ctrl_mem_req,
   input  mem_bus_pkg::mem_resp_t            mem_resp,
   output logic                              flush_way,
   output logic [cache_cfg_pkg::IDX_W-1:0]   flush_idx,
   output mem_bus_pkg::mem_resp_t            ctrl_mem_resp,
   output mem_bus_pkg::mem_req_t             mem_req,
   output logic                              flushed
);
   import cache_cfg_pkg::*;

   typedef enum logic [1:0] {f_idle, f_walk, f_count, f_done} state_t;

   state_t           state;
   state_t           state_nxt;
   logic [BLK_W-1:0] off;
   logic [BLK_W-1:0] off_nxt;
   logic             way_nxt;
   logic [IDX_W-1:0] idx_nxt;
   logic             step;
   logic             last_idx;

   assign last_idx = (flush_idx == IDX_W'(NUM_SETS - 1));
   assign flushed  = (state == f_done);

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state     <= f_idle;
         flush_way <= 1'b0;
         flush_idx <= '0;
         off       <= '0;
      end
      else
      begin
         state     <= state_nxt;
         flush_way <= way_nxt;
         flush_idx <= idx_nxt;
         off       <= off_nxt;
      end
   end

   always_comb
   begin
      state_nxt     = state;
      way_nxt       = flush_way;
      idx_nxt       = flush_idx;
      off_nxt       = off;
      step          = 1'b0;
      mem_req       = '0;
      ctrl_mem_resp = '0;
      case (state)
         f_idle:
         begin
            // controller has the port
            mem_req       = ctrl_mem_req;
            ctrl_mem_resp = mem_resp;
            if (flush_start)
            begin
               state_nxt = f_walk;
            end
         end
         f_walk:
         begin
            if (flush_frame.valid && flush_frame.dirty)
            begin
               // both words, word 0 first
               mem_req.valid = 1'b1;
               mem_req.wr    = 1'b1;
               mem_req.addr  = make_addr(flush_frame.tag, flush_idx, off);
               mem_req.wdata = flush_frame.data[off];
               if (mem_resp.ready)
               begin
                  off_nxt = ~off;
                  step    = (off == 1'b1);
               end
            end
            else
            begin
               // clean frame, one cycle
               step = 1'b1;
            end
            // next set, way 0 then way 1
            if (step)
            begin
               if (last_idx)
               begin
                  idx_nxt = '0;
                  way_nxt = 1'b1;
                  if (flush_way)
                  begin
                     state_nxt = f_count;
                  end
               end
               else
               begin
                  idx_nxt = flush_idx + 1'b1;
               end
            end
         end
         f_count:
         begin
            // hit counter after the last block
            mem_req.valid    = 1'b1;
            mem_req.wr       = 1'b1;
            mem_req.addr.raw = HIT_COUNT_ADDR;
            mem_req.wdata    = hit_count;
            if (mem_resp.ready)
            begin
               state_nxt = f_done;
            end
         end
         default:
         begin
            // flushed held until reset
         end
      endcase
   end

endmodule

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top
#(
   parameter int                                NUM_SETS       = cache_cfg_pkg::NUM_SETS,
   parameter logic [cache_cfg_pkg::ADDR_W-1:0]  HIT_COUNT_ADDR = cache_cfg_pkg::HIT_COUNT_ADDR
)
(
   input  logic                    CLK,
   input  logic                    nRST,
   input  mem_bus_pkg::cpu_req_t   cpu_req,
   input  logic                    halt,
   input  mem_bus_pkg::mem_resp_t  mem_resp,
   output mem_bus_pkg::cpu_resp_t  cpu_resp,
   output mem_bus_pkg::mem_req_t   mem_req,
   output logic                    flushed
);
   import cache_cfg_pkg::*;
   import mem_bus_pkg::*;

   // lookup and update between controller and arrays
   addr_u             lookup_addr;
   logic              hit;
   logic              hit_way;
   logic              victim_way;
   frame_t            victim_frame;
   frame_t            hit_frame;
   logic              fill_en;
   logic              fill_way;
   frame_t            fill_frame;
   logic              touch_en;

   // flush side
   logic              flush_way;
   logic [IDX_W-1:0]  flush_idx;
   frame_t            flush_frame;
   logic              flush_start;
   logic [WORD_W-1:0] hit_count;

   // controller memory port, routed through the flush engine
   mem_req_t          ctrl_mem_req;
   mem_resp_t         ctrl_mem_resp;

   dcache_ways #(.NUM_SETS(NUM_SETS)) i_ways (
      .CLK(CLK), .nRST(nRST), .lookup_addr(lookup_addr),
      .fill_en(fill_en), .fill_way(fill_way), .fill_frame(fill_frame),
      .touch_en(touch_en), .flush_way(flush_way), .flush_idx(flush_idx),
      .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
      .victim_frame(victim_frame), .hit_frame(hit_frame), .flush_frame(flush_frame)
   );

   dcache_ctrl i_ctrl (
      .CLK(CLK), .nRST(nRST), .cpu_req(cpu_req), .halt(halt),
      .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
      .victim_frame(victim_frame), .hit_frame(hit_frame),
      .ctrl_mem_resp(ctrl_mem_resp), .cpu_resp(cpu_resp), .ctrl_mem_req(ctrl_mem_req),
      .lookup_addr(lookup_addr), .fill_en(fill_en), .fill_way(fill_way),
      .fill_frame(fill_frame), .touch_en(touch_en), .flush_start(flush_start),
      .hit_count(hit_count)
   );

   dcache_flush #(.NUM_SETS(NUM_SETS), .HIT_COUNT_ADDR(HIT_COUNT_ADDR)) i_flush (
      .CLK(CLK), .nRST(nRST), .flush_start(flush_start), .hit_count(hit_count),
      .flush_frame(flush_frame), .ctrl_mem_req(ctrl_mem_req), .mem_resp(mem_resp),
      .flush_way(flush_way), .flush_idx(flush_idx), .ctrl_mem_resp(ctrl_mem_resp),
      .mem_req(mem_req), .flushed(flushed)
   );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
   parameter int HALF_NS      = 4,
   parameter int RESET_CYCLES = 5
)
(
   output logic CLK,
   output logic nRST
);

   // free running, 8 ns period
   initial
   begin
      CLK = 1'b0;
      forever
      begin
         #(HALF_NS) CLK = ~CLK;
      end
   end

   // reset low for a few edges, released just after one
   initial
   begin
      nRST = 1'b0;
      repeat (RESET_CYCLES) @(posedge CLK);
      #1 nRST = 1'b1;
   end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
(
   input  logic                   CLK,
   input  logic                   nRST,
   input  mem_bus_pkg::mem_req_t  mem_req,
   output mem_bus_pkg::mem_resp_t mem_resp,
   input  mem_bus_pkg::cpu_req_t  cpu_req,
   input  mem_bus_pkg::cpu_resp_t cpu_resp,
   input  logic                   load_en,
   input  logic [31:0]            load_addr,
   input  logic [31:0]            load_data,
   input  logic [31:0]            peek_addr,
   output logic [31:0]            peek_mem,
   output logic [31:0]            peek_shadow
);
   localparam int          WORDS = 4096;
   localparam logic [15:0] SEED  = 16'd44577;

   // 16 KB window, upper address bits ignored
   logic [31:0] mem [WORDS];
   // each word as last written by preload or by the processor
   logic [31:0] shadow [WORDS];
   logic [15:0] lfsr;
   logic [15:0] lfsr_a;
   logic [15:0] lfsr_b;
   logic        ready;

   // galois form, taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0])
      begin
         n = n ^ 16'hB400;
      end
      return n;
   endfunction

   function automatic int word_idx(input logic [31:0] a);
      return int'(a[13:2]);
   endfunction

   initial
   begin
      for (int i = 0; i < WORDS; i++)
      begin
         mem[i]    = '0;
         shadow[i] = '0;
      end
   end

   // two bits taken per cycle, ready roughly three cycles in four
   assign lfsr_a = lfsr_step(lfsr);
   assign lfsr_b = lfsr_step(lfsr_a);

   always @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         lfsr  <= SEED;
         ready <= 1'b0;
      end
      else
      begin
         lfsr  <= lfsr_b;
         ready <= lfsr[0] | lfsr_a[0];
      end
   end

   always @(posedge CLK)
   begin
      // preload lands in both copies
      if (load_en)
      begin
         mem[word_idx(load_addr)]    <= load_data;
         shadow[word_idx(load_addr)] <= load_data;
      end
      // cache writes, on the accepted cycle only
      if (mem_req.valid && mem_req.wr && ready)
      begin
         mem[word_idx(mem_req.addr.raw)] <= mem_req.wdata;
      end
      // completed processor stores
      if (cpu_resp.hit && cpu_req.wr)
      begin
         shadow[word_idx(cpu_req.addr.raw)] <= cpu_req.wdata;
      end
   end

   always_comb
   begin
      mem_resp.ready = ready;
      mem_resp.rdata = mem[word_idx(mem_req.addr.raw)];
   end

   // unclocked view for the end of run compare
   assign peek_mem    = mem[word_idx(peek_addr)];
   assign peek_shadow = shadow[word_idx(peek_addr)];

endmodule

//--- dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
   import cache_cfg_pkg::*;
   import mem_bus_pkg::*;

   localparam int          NUM_ENTRIES   = 22;
   localparam int          LIMIT_CYCLES  = NUM_ENTRIES * 64 + 2000;
   localparam logic [31:0] PRELOAD_BASE  = 32'h0000_1000;
   localparam int          PRELOAD_WORDS = 128;
   localparam int          MEM_WORDS     = 4096;

   // one table row, wb is the write transfers expected before the fetch
   typedef struct packed {
      logic        wr;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [31:0] rdata;
      logic        hit;
      logic [1:0]  wb;
   } entry_t;

   logic        CLK;
   logic        nRST;
   cpu_req_t    cpu_req;
   cpu_resp_t   cpu_resp;
   mem_req_t    mem_req;
   mem_resp_t   mem_resp;
   logic        halt;
   logic        flushed;
   logic        load_en;
   logic [31:0] load_addr;
   logic [31:0] load_data;
   logic [31:0] peek_addr;
   logic [31:0] peek_mem;
   logic [31:0] peek_shadow;

   entry_t stim [NUM_ENTRIES];
   int     fill_pos;
   int     hit_total;
   int     errors;
   int     checks;
   int     tests;
   int     mem_reqs;
   int     mem_writes;

   tb_clock_gen i_clk (.CLK(CLK), .nRST(nRST));

   dcache_top #(.NUM_SETS(NUM_SETS), .HIT_COUNT_ADDR(HIT_COUNT_ADDR)) i_dut (
      .CLK(CLK), .nRST(nRST), .cpu_req(cpu_req), .halt(halt), .mem_resp(mem_resp),
      .cpu_resp(cpu_resp), .mem_req(mem_req), .flushed(flushed)
   );

   tb_mem_model i_mem (
      .CLK(CLK), .nRST(nRST), .mem_req(mem_req), .mem_resp(mem_resp),
      .cpu_req(cpu_req), .cpu_resp(cpu_resp), .load_en(load_en),
      .load_addr(load_addr), .load_data(load_data), .peek_addr(peek_addr),
      .peek_mem(peek_mem), .peek_shadow(peek_shadow)
   );

   // preload pattern, every address bit matters
   function automatic logic [31:0] preload_word(input logic [31:0] a);
      return a ^ {a[15:0], a[31:16]} ^ 32'h6C3A_19E5;
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Fail at %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      $display("test %s: %s", name, (errors == errs_before) ? "ok" : "mismatch");
   endtask

   task automatic add_entry(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] rdata, input logic hit, input logic [1:0] wb);
      stim[fill_pos] = '{wr, addr, wdata, rdata, hit, wb};
      fill_pos++;
      hit_total += int'(hit);
   endtask

   // set = addr[5:3], tag step 0x40, lru per set picks way 0 first
   task automatic build_table();
      fill_pos  = 0;
      hit_total = 0;
      add_entry(0, 32'h1000, 0, preload_word(32'h1000), 0, 0);
      add_entry(0, 32'h1004, 0, preload_word(32'h1004), 1, 0);
      add_entry(1, 32'h1000, 32'hDEAD_0001, 0, 1, 0);
      add_entry(0, 32'h1000, 0, 32'hDEAD_0001, 1, 0);
      // second tag of set 0 into way 1
      add_entry(0, 32'h1040, 0, preload_word(32'h1040), 0, 0);
      add_entry(0, 32'h1000, 0, 32'hDEAD_0001, 1, 0);
      // third tag, upper word first, way 1 replaced
      add_entry(0, 32'h1084, 0, preload_word(32'h1084), 0, 0);
      add_entry(0, 32'h1080, 0, preload_word(32'h1080), 1, 0);
      // dirty way 0 goes out before the fetch
      add_entry(0, 32'h1044, 0, preload_word(32'h1044), 0, 2);
      add_entry(0, 32'h1000, 0, 32'hDEAD_0001, 0, 0);
      // write misses in set 1
      add_entry(1, 32'h100C, 32'hBEEF_0002, 0, 0, 0);
      add_entry(0, 32'h100C, 0, 32'hBEEF_0002, 1, 0);
      add_entry(0, 32'h1008, 0, preload_word(32'h1008), 1, 0);
      add_entry(1, 32'h1048, 32'hCAFE_0003, 0, 0, 0);
      add_entry(1, 32'h108C, 32'h0BAD_0004, 0, 0, 2);
      add_entry(0, 32'h100C, 0, 32'hBEEF_0002, 0, 2);
      add_entry(0, 32'h1048, 0, 32'hCAFE_0003, 0, 2);
      // set 2, left dirty for the flush
      add_entry(1, 32'h1010, 32'h1234_5678, 0, 0, 0);
      add_entry(1, 32'h1014, 32'h9ABC_DEF0, 0, 1, 0);
      add_entry(0, 32'h1010, 0, 32'h1234_5678, 1, 0);
      add_entry(1, 32'h1004, 32'h55AA_7007, 0, 1, 0);
      add_entry(0, 32'h108C, 0, 32'h0BAD_0004, 0, 0);
   endtask

   task automatic run_entry(input int n);
      entry_t      e;
      int          waited;
      int          reqs0;
      int          writes0;
      int          errs0;
      logic [31:0] got;
      e       = stim[n];
      waited  = 0;
      reqs0   = mem_reqs;
      writes0 = mem_writes;
      errs0   = errors;
      cpu_req.rd       = ~e.wr;
      cpu_req.wr       = e.wr;
      cpu_req.addr.raw = e.addr;
      cpu_req.wdata    = e.wdata;
      // request held until hit, watched mid cycle
      @(negedge CLK);
      while (cpu_resp.hit !== 1'b1)
      begin
         waited++;
         @(negedge CLK);
      end
      got = cpu_resp.rdata;
      @(posedge CLK);
      #1;
      cpu_req = '0;
      if (!e.wr)
      begin
         check(got, e.rdata, $sformatf("read data at %h", e.addr));
      end
      check(32'(waited == 0), 32'(e.hit), $sformatf("hit in request cycle at %h", e.addr));
      if (e.hit)
      begin
         check(mem_reqs - reqs0, 0, "memory request during a hit");
      end
      check(mem_writes - writes0, 32'(e.wb), $sformatf("writebacks before %h", e.addr));
      report_test($sformatf("%0d %s %h", n, e.wr ? "wr" : "rd", e.addr), errs0);
   endtask

   // bus watch, sampled mid cycle where everything has settled
   always @(negedge CLK)
   begin
      if (nRST && mem_req.valid)
      begin
         mem_reqs++;
         if (mem_req.wr && mem_resp.ready)
         begin
            mem_writes++;
         end
      end
      if (nRST && cpu_resp.hit && !(cpu_req.rd || cpu_req.wr))
      begin
         check(32'(cpu_resp.hit), 0, "hit raised with no request open");
      end
   end

   initial
   begin
      int errs0;
      cpu_req   = '0;
      halt      = 1'b0;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      peek_addr = '0;
      errors    = 0;
      checks    = 0;
      tests     = 0;
      build_table();
      wait (nRST === 1'b1);
      @(negedge CLK);
      errs0 = errors;
      check(32'(cpu_resp.hit), 0, "hit after reset");
      check(32'(mem_req.valid), 0, "memory valid after reset");
      check(32'(flushed), 0, "flushed after reset");
      report_test("reset", errs0);
      @(posedge CLK);
      #1;
      // one word per cycle while the cache sits idle
      for (int i = 0; i < PRELOAD_WORDS; i++)
      begin
         load_en   = 1'b1;
         load_addr = PRELOAD_BASE + 32'(i * 4);
         load_data = preload_word(load_addr);
         @(posedge CLK);
         #1;
      end
      load_en = 1'b0;
      for (int n = 0; n < NUM_ENTRIES; n++)
      begin
         run_entry(n);
      end
      // halt, then memory must match the shadow copy
      errs0 = errors;
      halt  = 1'b1;
      while (flushed !== 1'b1)
      begin
         @(negedge CLK);
      end
      for (int a = 0; a < MEM_WORDS; a++)
      begin
         peek_addr = 32'(a * 4);
         #1;
         if (peek_addr == HIT_COUNT_ADDR)
         begin
            check(peek_mem, 32'(hit_total), "stored hit count");
         end
         else
         begin
            check(peek_mem, peek_shadow, $sformatf("memory word %h", peek_addr));
         end
      end
      report_test("flush", errs0);
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
      begin
         $display("SIMULATION PASSED");
      end
      else
      begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // bound scales with the table length
   initial
   begin
      repeat (LIMIT_CYCLES) @(posedge CLK);
      $display("timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

//--- verilog.f
cache_cfg_pkg.sv
mem_bus_pkg.sv
dcache_ways.sv
dcache_ctrl.sv
dcache_flush.sv
dcache_top.sv
tb_clock_gen.sv
tb_mem_model.sv
dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the data cache testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f verilog.f \
   --top-module dcache_tb -o dcache_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/dcache_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
